//--- tnoc_lite_pkg.sv
package tnoc_lite_pkg;

  // node coordinates and virtual channel.
  localparam int ID_X_WIDTH = 2;
  localparam int ID_Y_WIDTH = 2;
  localparam int VC_WIDTH   = 1;

  // AXI side widths.
  localparam int ADDR_WIDTH   = 32;
  localparam int DATA_WIDTH   = 32;
  localparam int STRB_WIDTH   = 4;
  localparam int AXI_ID_WIDTH = 4;

  // the address map has contiguous regions from address zero.
  localparam int REGION_SIZE  = 'h1000;
  localparam int REGION_COUNT = 4;

  // destination node of each region with entry 0 as the rightmost one.
  localparam logic [REGION_COUNT-1:0][ID_X_WIDTH-1:0] REGION_X = {
    2'd2, 2'd1, 2'd2, 2'd1
  };
  localparam logic [REGION_COUNT-1:0][ID_Y_WIDTH-1:0] REGION_Y = {
    2'd1, 2'd1, 2'd0, 2'd0
  };

  typedef enum logic [1:0] {
    FLIT_WRITE_REQ          = 2'd0,
    FLIT_READ_REQ           = 2'd1,
    FLIT_RESPONSE           = 2'd2,
    FLIT_RESPONSE_WITH_DATA = 2'd3
  } tnoc_lite_flit_type_e;

  // encodings follow the AXI BRESP and RRESP values.
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } tnoc_lite_resp_e;

  // a single flit carries both header and payload.
  typedef struct packed {
    tnoc_lite_flit_type_e    flit_type;
    logic [ID_X_WIDTH-1:0]   dest_x;
    logic [ID_Y_WIDTH-1:0]   dest_y;
    logic [ID_X_WIDTH-1:0]   src_x;
    logic [ID_Y_WIDTH-1:0]   src_y;
    logic [VC_WIDTH-1:0]     vc;
    logic [AXI_ID_WIDTH-1:0] id;
    logic [ADDR_WIDTH-1:0]   addr;
    logic [DATA_WIDTH-1:0]   data;
    logic [STRB_WIDTH-1:0]   strb;
    tnoc_lite_resp_e         resp;
  } tnoc_lite_flit_t;

endpackage

//--- tnoc_lite_addr_decoder.sv
module tnoc_lite_addr_decoder (
  input  logic [tnoc_lite_pkg::ADDR_WIDTH-1:0] i_addr,
  output logic [tnoc_lite_pkg::ID_X_WIDTH-1:0] o_dest_x,
  output logic [tnoc_lite_pkg::ID_Y_WIDTH-1:0] o_dest_y,
  output logic                                 o_decode_error
);
  import tnoc_lite_pkg::*;

  // the address misses unless a matching region overrides the default.
  always_comb begin
    o_dest_x       = '0;
    o_dest_y       = '0;
    o_decode_error = 1'b1;
    for (int i = 0; i < REGION_COUNT; i++) begin
      if ((i_addr >= ADDR_WIDTH'(i * REGION_SIZE)) &&
          (i_addr <  ADDR_WIDTH'((i + 1) * REGION_SIZE))) begin
        o_dest_x       = REGION_X[i];
        o_dest_y       = REGION_Y[i];
        o_decode_error = 1'b0;
      end
    end
  end

endmodule

//--- tnoc_lite_write_adapter.sv
module tnoc_lite_write_adapter (
  input  logic                                   clk,
  input  logic                                   i_rst_n,
  input  logic [tnoc_lite_pkg::ID_X_WIDTH-1:0]   i_id_x,
  input  logic [tnoc_lite_pkg::ID_Y_WIDTH-1:0]   i_id_y,
  input  logic [tnoc_lite_pkg::VC_WIDTH-1:0]     i_vc,
  input  logic                                   i_awvalid,
  output logic                                   o_awready,
  input  logic [tnoc_lite_pkg::AXI_ID_WIDTH-1:0] i_awid,
  input  logic [tnoc_lite_pkg::ADDR_WIDTH-1:0]   i_awaddr,
  input  logic                                   i_wvalid,
  output logic                                   o_wready,
  input  logic [tnoc_lite_pkg::DATA_WIDTH-1:0]   i_wdata,
  input  logic [tnoc_lite_pkg::STRB_WIDTH-1:0]   i_wstrb,
  output logic                                   o_bvalid,
  input  logic                                   i_bready,
  output logic [tnoc_lite_pkg::AXI_ID_WIDTH-1:0] o_bid,
  output tnoc_lite_pkg::tnoc_lite_resp_e         o_bresp,
  output logic                                   o_req_valid,
  output tnoc_lite_pkg::tnoc_lite_flit_t         o_req_flit,
  input  logic                                   i_req_ready,
  input  logic                                   i_rsp_valid,
  input  tnoc_lite_pkg::tnoc_lite_flit_t         i_rsp_flit,
  output logic                                   o_rsp_ready
);
  import tnoc_lite_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    REQUEST,
    WAIT_RESPONSE,
    RESPOND
  } write_state_e;

  write_state_e            state;
  logic                    aw_full;
  logic                    w_full;
  logic [AXI_ID_WIDTH-1:0] awid_q;
  logic [ADDR_WIDTH-1:0]   awaddr_q;
  logic [DATA_WIDTH-1:0]   wdata_q;
  logic [STRB_WIDTH-1:0]   wstrb_q;
  logic [AXI_ID_WIDTH-1:0] bid_q;
  tnoc_lite_resp_e         bresp_q;
  logic [ID_X_WIDTH-1:0]   dest_x;
  logic [ID_Y_WIDTH-1:0]   dest_y;
  logic                    decode_error;
  logic                    local_error;
  logic                    aw_hs;
  logic                    w_hs;
  logic                    b_hs;

  tnoc_lite_addr_decoder u_decoder (
    .i_addr         (awaddr_q     ),
    .o_dest_x       (dest_x       ),
    .o_dest_y       (dest_y       ),
    .o_decode_error (decode_error )
  );

  assign aw_hs = i_awvalid && o_awready;
  assign w_hs  = i_wvalid && o_wready;
  assign b_hs  = o_bvalid && i_bready;

  // a missed address is answered here, in place of the request.
  assign local_error = (state == REQUEST) && decode_error;

  assign o_awready   = !aw_full;
  assign o_wready    = !w_full;
  assign o_req_valid = (state == REQUEST) && !decode_error;
  assign o_rsp_ready = (state == WAIT_RESPONSE);
  assign o_bvalid    = (state == RESPOND) || local_error;
  assign o_bid       = local_error ? awid_q : bid_q;
  assign o_bresp     = local_error ? RESP_DECERR : bresp_q;

  always_comb begin
    o_req_flit           = '0;
    o_req_flit.flit_type = FLIT_WRITE_REQ;
    o_req_flit.dest_x    = dest_x;
    o_req_flit.dest_y    = dest_y;
    o_req_flit.src_x     = i_id_x;
    o_req_flit.src_y     = i_id_y;
    o_req_flit.vc        = i_vc;
    o_req_flit.id        = awid_q;
    o_req_flit.addr      = awaddr_q;
    o_req_flit.data      = wdata_q;
    o_req_flit.strb      = wstrb_q;
    o_req_flit.resp      = RESP_OKAY;
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state   <= IDLE;
      aw_full <= 1'b0;
      w_full  <= 1'b0;
    end else begin
      // the holding registers stay full until B completes.
      if (b_hs) begin
        aw_full <= 1'b0;
        w_full  <= 1'b0;
      end else begin
        aw_full <= aw_full || aw_hs;
        w_full  <= w_full || w_hs;
      end
      case (state)
        IDLE:          if ((aw_full || aw_hs) && (w_full || w_hs)) state <= REQUEST;
        REQUEST: begin
          if (decode_error) begin
            if (i_bready) state <= IDLE;
          end else if (i_req_ready) begin
            state <= WAIT_RESPONSE;
          end
        end
        WAIT_RESPONSE: if (i_rsp_valid) state <= RESPOND;
        RESPOND:       if (i_bready) state <= IDLE;
        default:       state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      awid_q   <= i_awid;
      awaddr_q <= i_awaddr;
    end
    if (w_hs) begin
      wdata_q <= i_wdata;
      wstrb_q <= i_wstrb;
    end
    if (i_rsp_valid && o_rsp_ready) begin
      bid_q   <= i_rsp_flit.id;
      bresp_q <= i_rsp_flit.resp;
    end
  end

endmodule

//--- tnoc_lite_read_adapter.sv
module tnoc_lite_read_adapter (
  input  logic                                   clk,
  input  logic                                   i_rst_n,
  input  logic [tnoc_lite_pkg::ID_X_WIDTH-1:0]   i_id_x,
  input  logic [tnoc_lite_pkg::ID_Y_WIDTH-1:0]   i_id_y,
  input  logic [tnoc_lite_pkg::VC_WIDTH-1:0]     i_vc,
  input  logic                                   i_arvalid,
  output logic                                   o_arready,
  input  logic [tnoc_lite_pkg::AXI_ID_WIDTH-1:0] i_arid,
  input  logic [tnoc_lite_pkg::ADDR_WIDTH-1:0]   i_araddr,
  output logic                                   o_rvalid,
  input  logic                                   i_rready,
  output logic [tnoc_lite_pkg::AXI_ID_WIDTH-1:0] o_rid,
  output logic [tnoc_lite_pkg::DATA_WIDTH-1:0]   o_rdata,
  output tnoc_lite_pkg::tnoc_lite_resp_e         o_rresp,
  output logic                                   o_req_valid,
  output tnoc_lite_pkg::tnoc_lite_flit_t         o_req_flit,
  input  logic                                   i_req_ready,
  input  logic                                   i_rsp_valid,
  input  tnoc_lite_pkg::tnoc_lite_flit_t         i_rsp_flit,
  output logic                                   o_rsp_ready
);
  import tnoc_lite_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    REQUEST,
    WAIT_RESPONSE,
    RESPOND
  } read_state_e;

  read_state_e             state;
  logic                    ar_full;
  logic [AXI_ID_WIDTH-1:0] arid_q;
  logic [ADDR_WIDTH-1:0]   araddr_q;
  logic [AXI_ID_WIDTH-1:0] rid_q;
  logic [DATA_WIDTH-1:0]   rdata_q;
  tnoc_lite_resp_e         rresp_q;
  logic [ID_X_WIDTH-1:0]   dest_x;
  logic [ID_Y_WIDTH-1:0]   dest_y;
  logic                    decode_error;
  logic                    local_error;
  logic                    ar_hs;

  tnoc_lite_addr_decoder u_decoder (
    .i_addr         (araddr_q     ),
    .o_dest_x       (dest_x       ),
    .o_dest_y       (dest_y       ),
    .o_decode_error (decode_error )
  );

  assign ar_hs       = i_arvalid && o_arready;
  assign local_error = (state == REQUEST) && decode_error;

  assign o_arready   = !ar_full;
  assign o_req_valid = (state == REQUEST) && !decode_error;
  assign o_rsp_ready = (state == WAIT_RESPONSE);
  // local error beats carry zero data.
  assign o_rvalid    = (state == RESPOND) || local_error;
  assign o_rid       = local_error ? arid_q : rid_q;
  assign o_rdata     = local_error ? '0 : rdata_q;
  assign o_rresp     = local_error ? RESP_DECERR : rresp_q;

  always_comb begin
    o_req_flit           = '0;
    o_req_flit.flit_type = FLIT_READ_REQ;
    o_req_flit.dest_x    = dest_x;
    o_req_flit.dest_y    = dest_y;
    o_req_flit.src_x     = i_id_x;
    o_req_flit.src_y     = i_id_y;
    o_req_flit.vc        = i_vc;
    o_req_flit.id        = arid_q;
    o_req_flit.addr      = araddr_q;
    o_req_flit.resp      = RESP_OKAY;
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state   <= IDLE;
      ar_full <= 1'b0;
    end else begin
      if (o_rvalid && i_rready) begin
        ar_full <= 1'b0;
      end else if (ar_hs) begin
        ar_full <= 1'b1;
      end
      case (state)
        IDLE:          if (ar_hs) state <= REQUEST;
        REQUEST: begin
          if (decode_error) begin
            if (i_rready) state <= IDLE;
          end else if (i_req_ready) begin
            state <= WAIT_RESPONSE;
          end
        end
        WAIT_RESPONSE: if (i_rsp_valid) state <= RESPOND;
        RESPOND:       if (i_rready) state <= IDLE;
        default:       state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      arid_q   <= i_arid;
      araddr_q <= i_araddr;
    end
    if (i_rsp_valid && o_rsp_ready) begin
      rid_q   <= i_rsp_flit.id;
      rdata_q <= i_rsp_flit.data;
      rresp_q <= i_rsp_flit.resp;
    end
  end

endmodule

//--- tnoc_lite_flit_mux.sv
module tnoc_lite_flit_mux (
  input  logic                           clk,
  input  logic                           i_rst_n,
  input  logic                           i_write_valid,
  input  tnoc_lite_pkg::tnoc_lite_flit_t i_write_flit,
  output logic                           o_write_ready,
  input  logic                           i_read_valid,
  input  tnoc_lite_pkg::tnoc_lite_flit_t i_read_flit,
  output logic                           o_read_ready,
  output logic                           o_flit_valid,
  output tnoc_lite_pkg::tnoc_lite_flit_t o_flit,
  input  logic                           i_flit_ready
);
  import tnoc_lite_pkg::*;

  logic            flit_valid_q;
  tnoc_lite_flit_t flit_q;
  logic            prio_read;
  logic            accept;
  logic            grant_write;
  logic            grant_read;

  // the output register takes a new flit when empty or draining.
  assign accept = !flit_valid_q || i_flit_ready;

  // on a tie, the side that lost the last contest goes first.
  assign grant_write = i_write_valid && (!i_read_valid || !prio_read);
  assign grant_read  = i_read_valid && !grant_write;

  assign o_write_ready = accept && grant_write;
  assign o_read_ready  = accept && grant_read;
  assign o_flit_valid  = flit_valid_q;
  assign o_flit        = flit_q;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      flit_valid_q <= 1'b0;
      prio_read    <= 1'b0;
    end else if (accept) begin
      flit_valid_q <= i_write_valid || i_read_valid;
      if (i_write_valid && i_read_valid) begin
        prio_read <= !prio_read;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept && grant_write) begin
      flit_q <= i_write_flit;
    end else if (accept && grant_read) begin
      flit_q <= i_read_flit;
    end
  end

endmodule

//--- tnoc_lite_flit_demux.sv
module tnoc_lite_flit_demux (
  input  logic                           i_flit_valid,
  input  tnoc_lite_pkg::tnoc_lite_flit_t i_flit,
  output logic                           o_flit_ready,
  output logic                           o_write_valid,
  output tnoc_lite_pkg::tnoc_lite_flit_t o_write_flit,
  input  logic                           i_write_ready,
  output logic                           o_read_valid,
  output tnoc_lite_pkg::tnoc_lite_flit_t o_read_flit,
  input  logic                           i_read_ready
);
  import tnoc_lite_pkg::*;

  assign o_write_flit = i_flit;
  assign o_read_flit  = i_flit;

  // steer by flit type and drop request types with an acknowledge.
  always_comb begin
    o_write_valid = 1'b0;
    o_read_valid  = 1'b0;
    o_flit_ready  = 1'b1;
    case (i_flit.flit_type)
      FLIT_RESPONSE: begin
        o_write_valid = i_flit_valid;
        o_flit_ready  = i_write_ready;
      end
      FLIT_RESPONSE_WITH_DATA: begin
        o_read_valid = i_flit_valid;
        o_flit_ready = i_read_ready;
      end
      default: begin
        o_flit_ready = 1'b1;
      end
    endcase
  end

endmodule

//--- tnoc_lite_axi_slave_adapter.sv
module tnoc_lite_axi_slave_adapter (
  input  logic                                   clk,
  input  logic                                   i_rst_n,
  input  logic [tnoc_lite_pkg::ID_X_WIDTH-1:0]   i_id_x,
  input  logic [tnoc_lite_pkg::ID_Y_WIDTH-1:0]   i_id_y,
  input  logic [tnoc_lite_pkg::VC_WIDTH-1:0]     i_write_vc,
  input  logic [tnoc_lite_pkg::VC_WIDTH-1:0]     i_read_vc,
  input  logic                                   i_awvalid,
  output logic                                   o_awready,
  input  logic [tnoc_lite_pkg::AXI_ID_WIDTH-1:0] i_awid,
  input  logic [tnoc_lite_pkg::ADDR_WIDTH-1:0]   i_awaddr,
  input  logic                                   i_wvalid,
  output logic                                   o_wready,
  input  logic [tnoc_lite_pkg::DATA_WIDTH-1:0]   i_wdata,
  input  logic [tnoc_lite_pkg::STRB_WIDTH-1:0]   i_wstrb,
  output logic                                   o_bvalid,
  input  logic                                   i_bready,
  output logic [tnoc_lite_pkg::AXI_ID_WIDTH-1:0] o_bid,
  output tnoc_lite_pkg::tnoc_lite_resp_e         o_bresp,
  input  logic                                   i_arvalid,
  output logic                                   o_arready,
  input  logic [tnoc_lite_pkg::AXI_ID_WIDTH-1:0] i_arid,
  input  logic [tnoc_lite_pkg::ADDR_WIDTH-1:0]   i_araddr,
  output logic                                   o_rvalid,
  input  logic                                   i_rready,
  output logic [tnoc_lite_pkg::AXI_ID_WIDTH-1:0] o_rid,
  output logic [tnoc_lite_pkg::DATA_WIDTH-1:0]   o_rdata,
  output tnoc_lite_pkg::tnoc_lite_resp_e         o_rresp,
  output logic                                   o_flit_out_valid,
  input  logic                                   i_flit_out_ready,
  output tnoc_lite_pkg::tnoc_lite_flit_t         o_flit_out,
  input  logic                                   i_flit_in_valid,
  output logic                                   o_flit_in_ready,
  input  tnoc_lite_pkg::tnoc_lite_flit_t         i_flit_in
);
  import tnoc_lite_pkg::*;

  // request flits from the adapters into the mux.
  logic            write_req_valid;
  logic            write_req_ready;
  tnoc_lite_flit_t write_req_flit;
  logic            read_req_valid;
  logic            read_req_ready;
  tnoc_lite_flit_t read_req_flit;

  // response flits from the demux into the adapters.
  logic            write_rsp_valid;
  logic            write_rsp_ready;
  tnoc_lite_flit_t write_rsp_flit;
  logic            read_rsp_valid;
  logic            read_rsp_ready;
  tnoc_lite_flit_t read_rsp_flit;

  tnoc_lite_write_adapter u_write_adapter (
    .clk         (clk             ),
    .i_rst_n     (i_rst_n         ),
    .i_id_x      (i_id_x          ),
    .i_id_y      (i_id_y          ),
    .i_vc        (i_write_vc      ),
    .i_awvalid   (i_awvalid       ),
    .o_awready   (o_awready       ),
    .i_awid      (i_awid          ),
    .i_awaddr    (i_awaddr        ),
    .i_wvalid    (i_wvalid        ),
    .o_wready    (o_wready        ),
    .i_wdata     (i_wdata         ),
    .i_wstrb     (i_wstrb         ),
    .o_bvalid    (o_bvalid        ),
    .i_bready    (i_bready        ),
    .o_bid       (o_bid           ),
    .o_bresp     (o_bresp         ),
    .o_req_valid (write_req_valid ),
    .o_req_flit  (write_req_flit  ),
    .i_req_ready (write_req_ready ),
    .i_rsp_valid (write_rsp_valid ),
    .i_rsp_flit  (write_rsp_flit  ),
    .o_rsp_ready (write_rsp_ready )
  );

  tnoc_lite_read_adapter u_read_adapter (
    .clk         (clk            ),
    .i_rst_n     (i_rst_n        ),
    .i_id_x      (i_id_x         ),
    .i_id_y      (i_id_y         ),
    .i_vc        (i_read_vc      ),
    .i_arvalid   (i_arvalid      ),
    .o_arready   (o_arready      ),
    .i_arid      (i_arid         ),
    .i_araddr    (i_araddr       ),
    .o_rvalid    (o_rvalid       ),
    .i_rready    (i_rready       ),
    .o_rid       (o_rid          ),
    .o_rdata     (o_rdata        ),
    .o_rresp     (o_rresp        ),
    .o_req_valid (read_req_valid ),
    .o_req_flit  (read_req_flit  ),
    .i_req_ready (read_req_ready ),
    .i_rsp_valid (read_rsp_valid ),
    .i_rsp_flit  (read_rsp_flit  ),
    .o_rsp_ready (read_rsp_ready )
  );

  tnoc_lite_flit_mux u_flit_mux (
    .clk           (clk              ),
    .i_rst_n       (i_rst_n          ),
    .i_write_valid (write_req_valid  ),
    .i_write_flit  (write_req_flit   ),
    .o_write_ready (write_req_ready  ),
    .i_read_valid  (read_req_valid   ),
    .i_read_flit   (read_req_flit    ),
    .o_read_ready  (read_req_ready   ),
    .o_flit_valid  (o_flit_out_valid ),
    .o_flit        (o_flit_out       ),
    .i_flit_ready  (i_flit_out_ready )
  );

  tnoc_lite_flit_demux u_flit_demux (
    .i_flit_valid  (i_flit_in_valid ),
    .i_flit        (i_flit_in       ),
    .o_flit_ready  (o_flit_in_ready ),
    .o_write_valid (write_rsp_valid ),
    .o_write_flit  (write_rsp_flit  ),
    .i_write_ready (write_rsp_ready ),
    .o_read_valid  (read_rsp_valid  ),
    .o_read_flit   (read_rsp_flit   ),
    .i_read_ready  (read_rsp_ready  )
  );

endmodule

//--- tb_tnoc_lite_axi_slave_adapter.sv
module tb_tnoc_lite_axi_slave_adapter;
  timeunit 1ns;
  timeprecision 100ps;
  import tnoc_lite_pkg::*;

  localparam int TXN_COUNT = 48;
  localparam int CYCLE_LIMIT = 400 * TXN_COUNT;

  logic clk, i_rst_n, i_awvalid, i_wvalid, i_bready, i_arvalid, i_rready;
  logic i_flit_out_ready, i_flit_in_valid, o_flit_in_ready, o_flit_out_valid;
  logic o_awready, o_wready, o_bvalid, o_arready, o_rvalid;
  logic [1:0] i_id_x, i_id_y;
  logic [0:0] i_write_vc, i_read_vc;
  logic [3:0] i_awid, i_arid, o_bid, o_rid, i_wstrb;
  logic [31:0] i_awaddr, i_araddr, i_wdata, o_rdata;
  tnoc_lite_resp_e o_bresp, o_rresp;
  tnoc_lite_flit_t o_flit_out, i_flit_in;

  logic [31:0] lfsr = 32'd89373;
  logic [31:0] mem[logic [31:0]];
  logic [31:0] shadow[logic [31:0]];
  tnoc_lite_flit_t pending[$];
  tnoc_lite_flit_t req;
  logic [31:0] route_addr;
  int errors = 0;
  int cycles = 0;
  int delay = 0;
  logic bp_on = 0, lat_check = 0, conc_phase = 0, have_prev = 0, first_pending = 0;
  tnoc_lite_flit_type_e prev_type;
  logic aw_got = 0, w_got = 0;
  logic [3:0] exp_wid, exp_rid, exp_wstrb;
  logic [31:0] exp_waddr, exp_raddr, exp_wdata;

  tnoc_lite_axi_slave_adapter i_dut (.*);

  initial begin
    clk = 0;
    forever #20 clk = ~clk;
  end

  // galois lfsr stepped once for each bit taken.
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return r;
  endfunction

  // regions 0 to 3 map to nodes (1,0), (2,0), (1,1) and (2,1).
  function automatic logic [3:0] region_dest(logic [31:0] addr);
    return {(addr[12] ? 2'd2 : 2'd1), 1'b0, addr[13]};
  endfunction

  function automatic logic [31:0] merge(logic [31:0] old, logic [31:0] data, logic [3:0] strb);
    logic [31:0] r;
    r = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) r[8*b +: 8] = data[8*b +: 8];
    end
    return r;
  endfunction

  wire aw_hs = i_awvalid && o_awready;
  wire w_hs = i_wvalid && o_wready;
  wire last_w_hs = (aw_hs || aw_got) && (w_hs || w_got) && (aw_hs || w_hs);

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the run went past %0d cycles", CYCLE_LIMIT);
      $display("Finished with errors");
      $finish;
    end
  end

  always @(posedge clk) begin
    i_bready <= bp_on ? 1'(rand_bits(1)) : 1'b1;
    i_rready <= bp_on ? 1'(rand_bits(1)) : 1'b1;
    i_flit_out_ready <= bp_on ? 1'(rand_bits(1)) : 1'b1;
    if (o_bvalid && i_bready) begin
      aw_got <= 0;
      w_got <= 0;
    end else begin
      aw_got <= aw_got || aw_hs;
      w_got <= w_got || w_hs;
    end
  end

  // the remote memory model answers each request after a random delay.
  always @(posedge clk) begin
    if (o_flit_out_valid && i_flit_out_ready) begin
      req = o_flit_out;
      if (req.flit_type == FLIT_WRITE_REQ) begin
        route_addr = exp_waddr;
        assert ({req.id, req.addr, req.data, req.strb} ==
                {exp_wid, exp_waddr, exp_wdata, exp_wstrb} &&
                req.vc == i_write_vc)
        else begin
          $display("MISMATCH o_flit_out write payload: got %h expected id %h addr %h data %h",
                   req, exp_wid, exp_waddr, exp_wdata);
          errors++;
        end
      end else begin
        route_addr = exp_raddr;
        assert (req.flit_type == FLIT_READ_REQ && req.id == exp_rid &&
                req.addr == exp_raddr && req.vc == i_read_vc)
        else begin
          $display("MISMATCH o_flit_out read header: got %h expected id %h addr %h",
                   req, exp_rid, exp_raddr);
          errors++;
        end
      end
      assert ({req.dest_x, req.dest_y} == region_dest(route_addr) &&
              {req.src_x, req.src_y} == {i_id_x, i_id_y})
      else begin
        $display("MISMATCH o_flit_out route: got %h expected dest %h src %h",
                 {req.dest_x, req.dest_y, req.src_x, req.src_y},
                 region_dest(route_addr), {i_id_x, i_id_y});
        errors++;
      end
      // the first flit of each contested pair shows which side won.
      if (conc_phase && first_pending) begin
        if (have_prev) begin
          assert (req.flit_type != prev_type)
          else begin
            $display("the mux did not alternate between contested write and read requests");
            errors++;
          end
        end
        prev_type <= req.flit_type;
        have_prev <= 1;
        first_pending <= 0;
      end
      pending.push_back(req);
    end
    if (i_flit_in_valid && o_flit_in_ready) begin
      i_flit_in_valid <= 0;
      i_flit_in <= '0;
      delay <= rand_bits(3);
    end else if (!i_flit_in_valid && pending.size() > 0) begin
      if (delay > 0) begin
        delay <= delay - 1;
      end else begin
        req = pending.pop_front();
        if (!mem.exists(req.addr)) mem[req.addr] = '0;
        if (req.flit_type == FLIT_WRITE_REQ) begin
          mem[req.addr] = merge(mem[req.addr], req.data, req.strb);
          req.flit_type = FLIT_RESPONSE;
        end else begin
          req.data = mem[req.addr];
          req.flit_type = FLIT_RESPONSE_WITH_DATA;
        end
        {req.dest_x, req.dest_y, req.src_x, req.src_y} =
          {req.src_x, req.src_y, req.dest_x, req.dest_y};
        req.resp = RESP_OKAY;
        i_flit_in <= req;
        i_flit_in_valid <= 1;
      end
    end
  end

  a_flit_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_flit_out_valid && !i_flit_out_ready |=> o_flit_out_valid && $stable(o_flit_out))
  else begin
    $display("MISMATCH o_flit_out under back-pressure: was %h now %h",
             $past(o_flit_out), o_flit_out);
    errors++;
  end
  a_b_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_bvalid && !i_bready |=> o_bvalid && $stable({o_bid, o_bresp}))
  else begin
    $display("MISMATCH o_bid/o_bresp under back-pressure: was %h now %h",
             $past({o_bid, o_bresp}), {o_bid, o_bresp});
    errors++;
  end
  a_r_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_rvalid && !i_rready |=> o_rvalid && $stable({o_rid, o_rdata, o_rresp}))
  else begin
    $display("MISMATCH o_rid/o_rdata/o_rresp under back-pressure: was %h now %h",
             $past({o_rid, o_rdata, o_rresp}), {o_rid, o_rdata, o_rresp});
    errors++;
  end
  a_b_latency: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_flit_in_valid && o_flit_in_ready && i_flit_in.flit_type == FLIT_RESPONSE |=> o_bvalid)
  else begin
    $display("o_bvalid did not rise one cycle after the response flit");
    errors++;
  end
  a_r_latency: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_flit_in_valid && o_flit_in_ready &&
    i_flit_in.flit_type == FLIT_RESPONSE_WITH_DATA |=> o_rvalid)
  else begin
    $display("o_rvalid did not rise one cycle after the response-with-data flit");
    errors++;
  end
  a_req_latency: assert property (@(posedge clk) disable iff (!i_rst_n)
    lat_check && last_w_hs |-> ##1 !o_flit_out_valid ##1 o_flit_out_valid)
  else begin
    $display("o_flit_out_valid did not rise two cycles after the last AW/W transfer");
    errors++;
  end
  a_no_decerr_flit: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_flit_out_valid |-> o_flit_out.addr < 32'h4000)
  else begin
    $display("a flit was sent for unmapped address %h", o_flit_out.addr);
    errors++;
  end

  task automatic write_txn(logic [31:0] addr, logic decerr);
    logic [31:0] data;
    logic [3:0] strb, id;
    logic aw_done, w_done;
    data = rand_bits(32);
    strb = 4'(rand_bits(4));
    id = 4'(rand_bits(4));
    aw_done = 0;
    w_done = 0;
    {exp_wid, exp_waddr, exp_wdata, exp_wstrb} = {id, addr, data, strb};
    // AW and W go out together so a write request can meet a read request in the mux.
    i_awvalid <= 1;
    i_awid <= id;
    i_awaddr <= addr;
    i_wvalid <= 1;
    i_wdata <= data;
    i_wstrb <= strb;
    while (!(aw_done && w_done)) begin
      @(posedge clk);
      if (i_awvalid && o_awready) begin
        aw_done = 1;
        i_awvalid <= 0;
      end
      if (i_wvalid && o_wready) begin
        w_done = 1;
        i_wvalid <= 0;
      end
    end
    do @(posedge clk); while (!(o_bvalid && i_bready));
    assert (o_bid == id && o_bresp == (decerr ? RESP_DECERR : RESP_OKAY))
    else begin
      $display("MISMATCH o_bid/o_bresp: got %h/%h expected %h/%h", o_bid, o_bresp,
               id, decerr ? RESP_DECERR : RESP_OKAY);
      errors++;
    end
    if (!decerr) begin
      if (!shadow.exists(addr)) shadow[addr] = '0;
      shadow[addr] = merge(shadow[addr], data, strb);
    end
  endtask

  task automatic read_txn(logic [31:0] addr, logic decerr);
    logic [3:0] id;
    logic [31:0] exp;
    id = 4'(rand_bits(4));
    {exp_rid, exp_raddr} = {id, addr};
    i_arvalid <= 1;
    i_arid <= id;
    i_araddr <= addr;
    do @(posedge clk); while (!(i_arvalid && o_arready));
    i_arvalid <= 0;
    do @(posedge clk); while (!(o_rvalid && i_rready));
    exp = (decerr || !shadow.exists(addr)) ? '0 : shadow[addr];
    assert (o_rid == id && o_rdata == exp && o_rresp == (decerr ? RESP_DECERR : RESP_OKAY))
    else begin
      $display("MISMATCH o_rid/o_rdata/o_rresp: got %h/%h/%h expected %h/%h/%h",
               o_rid, o_rdata, o_rresp, id, exp, decerr ? RESP_DECERR : RESP_OKAY);
      errors++;
    end
  endtask

  function automatic logic [31:0] mapped_addr(logic [1:0] region);
    return {18'd0, region, 10'(rand_bits(10)), 2'b00};
  endfunction

  initial begin
    logic [31:0] a;
    {i_rst_n, i_awvalid, i_wvalid, i_arvalid, i_flit_in_valid} = '0;
    {i_bready, i_rready, i_flit_out_ready} = '1;
    {i_awid, i_arid, i_awaddr, i_araddr, i_wdata, i_wstrb} = '0;
    {i_id_x, i_id_y, i_write_vc, i_read_vc} = {2'd3, 2'd2, 1'b1, 1'b0};
    i_flit_in = '0;
    repeat (5) @(posedge clk);
    i_rst_n <= 1;
    @(posedge clk);
    assert (!o_bvalid && !o_rvalid && !o_flit_out_valid && o_awready && o_wready &&
            o_arready && o_flit_in_ready)
    else begin
      $display("the valid and ready outputs are wrong after reset");
      errors++;
    end
    $display("test reset_state finished, errors so far %0d", errors);

    lat_check <= 1;
    for (int i = 0; i < 8; i++) begin
      a = mapped_addr(2'(rand_bits(2)));
      write_txn(a, 0);
      read_txn(a, 0);
    end
    lat_check <= 0;
    $display("test write_then_read finished, errors so far %0d", errors);

    write_txn(32'h4000 + {20'd0, 10'(rand_bits(10)), 2'b00}, 1);
    read_txn(32'h4000 + {20'd0, 10'(rand_bits(10)), 2'b00}, 1);
    write_txn(32'hffff_f000, 1);
    read_txn(32'h8000_0000, 1);
    $display("test decode_error finished, errors so far %0d", errors);

    conc_phase <= 1;
    have_prev <= 0;
    for (int i = 0; i < 6; i++) begin
      first_pending <= 1;
      fork
        write_txn(mapped_addr({1'b0, 1'(rand_bits(1))}), 0);
        read_txn(mapped_addr({1'b1, 1'(rand_bits(1))}), 0);
      join
    end
    conc_phase <= 0;
    $display("test concurrent finished, errors so far %0d", errors);

    bp_on <= 1;
    for (int i = 0; i < 8; i++) begin
      a = mapped_addr(2'(rand_bits(2)));
      write_txn(a, 0);
      read_txn(a, 0);
    end
    bp_on <= 0;
    $display("test back_pressure finished, errors so far %0d", errors);

    $display("tests run: 5, errors: %0d", errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- tnoc_lite.f
tnoc_lite_pkg.sv
tnoc_lite_addr_decoder.sv
tnoc_lite_write_adapter.sv
tnoc_lite_read_adapter.sv
tnoc_lite_flit_mux.sv
tnoc_lite_flit_demux.sv
tnoc_lite_axi_slave_adapter.sv
tb_tnoc_lite_axi_slave_adapter.sv
